//--- common/spmm_pkg.sv
/* Sparse-dense product shared definitions */

package spmm_pkg;

  // ========================================
  // Datapath widths
  // ========================================

  // H value and weight, signed
  localparam int DATA_WIDTH = 8;

  // One column result, signed, wraps modulo 2^16
  localparam int WH_DATA_WIDTH = 16;

  // Subgraph node count in the node-info word
  localparam int NUM_NODE_WIDTH = 8;

  // Source flag in the node-info word
  localparam int FLAG_WIDTH = 1;

  // ========================================
  // Fixed depths
  // ========================================

  // Prefetched node-info words
  localparam int NODE_FIFO_DEPTH = 4;

  // ========================================
  // Default dimensions
  // ========================================

  // Columns of H, rows of W
  localparam int DEF_NUM_FEATURE_IN = 16;

  // Columns of W, one PE each
  localparam int DEF_NUM_FEATURE_OUT = 4;

  // Rows of H and WH words per run
  localparam int DEF_TOTAL_NODES = 8;

  // Depth of the H data memory
  localparam int DEF_H_NUM_SPARSE = 32;

endpackage

//--- src/node_info_fifo.sv
/* Node-info prefetch FIFO */

module node_info_fifo #(
  parameter int DATA_W = 14,
  parameter int DEPTH  = 4,
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  logic              pop_i,
  input  logic [DATA_W-1:0] din_i,
  output logic [DATA_W-1:0] dout_o,
  output logic              empty_o,
  output logic              full_o
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  // Head word falls through
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

endmodule

//--- spmm/spmm_row_fetch.sv
/* Sparse row fetch and element issue */

module spmm_row_fetch #(
  parameter int NUM_FEATURE_IN  = spmm_pkg::DEF_NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = spmm_pkg::DEF_NUM_FEATURE_OUT,
  parameter int TOTAL_NODES     = spmm_pkg::DEF_TOTAL_NODES,
  parameter int H_NUM_SPARSE    = spmm_pkg::DEF_H_NUM_SPARSE,
  localparam int COL_W          = $clog2(NUM_FEATURE_IN),
  localparam int ROW_LEN_W      = COL_W + 1,
  localparam int H_ADDR_W       = $clog2(H_NUM_SPARSE),
  localparam int NODE_ADDR_W    = $clog2(TOTAL_NODES),
  localparam int H_W            = COL_W + spmm_pkg::DATA_WIDTH,
  localparam int NI_W = ROW_LEN_W + spmm_pkg::NUM_NODE_WIDTH + spmm_pkg::FLAG_WIDTH
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  spmm_vld_i,
  input  logic [H_W-1:0]                                        h_data_i,
  input  logic [NI_W-1:0]                                       node_data_i,
  input  logic [NUM_FEATURE_OUT-1:0][spmm_pkg::DATA_WIDTH-1:0]  wgt_data_i,
  input  logic [NI_W-1:0]                                       ff_data_i,
  input  logic                                                  ff_empty_i,
  input  logic                                                  ff_full_i,
  input  logic                                                  done_i,
  output logic [H_ADDR_W-1:0]                                   h_addr_o,
  output logic [NODE_ADDR_W-1:0]                                node_addr_o,
  output logic [COL_W-1:0]                                      wgt_addr_o,
  output logic                                                  ff_push_o,
  output logic [NI_W-1:0]                                       ff_data_o,
  output logic                                                  ff_pop_o,
  output logic                                                  elem_vld_o,
  output logic [spmm_pkg::DATA_WIDTH-1:0]                       elem_val_o,
  output logic                                                  elem_last_o,
  output logic [spmm_pkg::NUM_NODE_WIDTH-1:0]                   elem_num_node_o,
  output logic [spmm_pkg::FLAG_WIDTH-1:0]                       elem_flag_o,
  output logic [NUM_FEATURE_OUT-1:0][spmm_pkg::DATA_WIDTH-1:0]  elem_wgt_o
);

  import spmm_pkg::*;

  localparam int NODE_CNT_W = $clog2(TOTAL_NODES + 1);

  logic [H_ADDR_W-1:0]       h_addr;
  logic [NODE_CNT_W-1:0]     node_cnt;
  logic [ROW_LEN_W-1:0]      row_cnt;
  logic                      node_rd;
  logic                      node_rd_q;
  logic [ROW_LEN_W-1:0]      head_len;
  logic [NUM_NODE_WIDTH-1:0] head_num_node;
  logic [FLAG_WIDTH-1:0]     head_flag;
  logic                      issue;
  logic                      row_end;
  logic [DATA_WIDTH-1:0]     rd_val;

  // Stage aligned with h_data_i
  logic                      s1_vld;
  logic                      s1_last;
  logic [NUM_NODE_WIDTH-1:0] s1_num_node;
  logic [FLAG_WIDTH-1:0]     s1_flag;

  // ========================================
  // Node-info prefetch
  // ========================================

  // One read in flight at a time, so a push never meets a full FIFO
  assign node_rd     = spmm_vld_i && !ff_full_i && !node_rd_q && (node_cnt < TOTAL_NODES);
  assign node_addr_o = node_cnt[NODE_ADDR_W-1:0];
  assign ff_push_o   = node_rd_q;
  assign ff_data_o   = node_data_i;

  // ========================================
  // Element issue
  // ========================================

  assign {head_len, head_num_node, head_flag} = ff_data_i;

  assign issue    = spmm_vld_i && !done_i && !ff_empty_i;
  assign row_end  = (row_cnt == head_len - ROW_LEN_W'(1));
  assign ff_pop_o = issue && row_end;
  assign h_addr_o = h_addr;

  // Column index addresses the weight row
  assign {wgt_addr_o, rd_val} = h_data_i;
  assign elem_wgt_o           = wgt_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_addr      <= '0;
      node_cnt    <= '0;
      row_cnt     <= '0;
      node_rd_q   <= 1'b0;
      s1_vld      <= 1'b0;
      s1_last     <= 1'b0;
      elem_vld_o  <= 1'b0;
      elem_last_o <= 1'b0;
    end else begin
      node_rd_q   <= node_rd;
      s1_vld      <= issue;
      s1_last     <= issue && row_end;
      elem_vld_o  <= s1_vld;
      elem_last_o <= s1_last;
      if (!spmm_vld_i) begin
        h_addr   <= '0;
        node_cnt <= '0;
        row_cnt  <= '0;
      end else begin
        if (node_rd) begin
          node_cnt <= node_cnt + 1'b1;
        end
        if (issue) begin
          h_addr  <= h_addr + 1'b1;
          row_cnt <= row_end ? '0 : row_cnt + 1'b1;
        end
      end
    end
  end

  // Payload follows the valid bits
  always_ff @(posedge clk) begin
    s1_num_node     <= head_num_node;
    s1_flag         <= head_flag;
    elem_val_o      <= rd_val;
    elem_num_node_o <= s1_num_node;
    elem_flag_o     <= s1_flag;
  end

endmodule

//--- spmm/sp_pe.sv
/* Sparse dot-product PE */

module sp_pe #(
  parameter int COL             = 0,
  parameter int NUM_FEATURE_OUT = spmm_pkg::DEF_NUM_FEATURE_OUT
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  elem_vld_i,
  input  logic [spmm_pkg::DATA_WIDTH-1:0]                       elem_val_i,
  input  logic                                                  elem_last_i,
  input  logic [spmm_pkg::NUM_NODE_WIDTH-1:0]                   elem_num_node_i,
  input  logic [spmm_pkg::FLAG_WIDTH-1:0]                       elem_flag_i,
  input  logic [NUM_FEATURE_OUT-1:0][spmm_pkg::DATA_WIDTH-1:0]  elem_wgt_i,
  output logic                                                  res_vld_o,
  output logic [spmm_pkg::WH_DATA_WIDTH-1:0]                    res_o,
  output logic [spmm_pkg::NUM_NODE_WIDTH-1:0]                   res_num_node_o,
  output logic [spmm_pkg::FLAG_WIDTH-1:0]                       res_flag_o
);

  import spmm_pkg::*;

  logic signed [DATA_WIDTH-1:0]    val;
  logic signed [DATA_WIDTH-1:0]    wgt;
  logic signed [2*DATA_WIDTH-1:0]  prod;
  logic signed [WH_DATA_WIDTH-1:0] prod_ext;
  logic signed [WH_DATA_WIDTH-1:0] acc;
  logic signed [WH_DATA_WIDTH-1:0] sum;

  // Own column of the broadcast weight row
  assign val      = elem_val_i;
  assign wgt      = elem_wgt_i[COL];
  assign prod     = val * wgt;
  assign prod_ext = prod;
  assign sum      = acc + prod_ext;

  // ========================================
  // Accumulate
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc       <= '0;
      res_vld_o <= 1'b0;
    end else begin
      res_vld_o <= elem_vld_i && elem_last_i;
      if (elem_vld_i) begin
        // Restart for the next row
        acc <= elem_last_i ? '0 : sum;
      end
    end
  end

  // Row result with its node fields
  always_ff @(posedge clk) begin
    if (elem_vld_i && elem_last_i) begin
      res_o          <= sum;
      res_num_node_o <= elem_num_node_i;
      res_flag_o     <= elem_flag_i;
    end
  end

endmodule

//--- spmm/spmm_wh_writer.sv
/* WH result writer */

module spmm_wh_writer #(
  parameter int NUM_FEATURE_OUT = spmm_pkg::DEF_NUM_FEATURE_OUT,
  parameter int TOTAL_NODES     = spmm_pkg::DEF_TOTAL_NODES,
  localparam int WH_ADDR_W      = $clog2(TOTAL_NODES),
  localparam int WH_W = NUM_FEATURE_OUT * spmm_pkg::WH_DATA_WIDTH
                      + spmm_pkg::NUM_NODE_WIDTH + spmm_pkg::FLAG_WIDTH
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     spmm_vld_i,
  input  logic                                                     res_vld_i,
  input  logic [NUM_FEATURE_OUT-1:0][spmm_pkg::WH_DATA_WIDTH-1:0]  res_i,
  input  logic [spmm_pkg::NUM_NODE_WIDTH-1:0]                      res_num_node_i,
  input  logic [spmm_pkg::FLAG_WIDTH-1:0]                          res_flag_i,
  output logic                                                     wh_we_o,
  output logic [WH_ADDR_W-1:0]                                     wh_addr_o,
  output logic [WH_W-1:0]                                          wh_data_o,
  output logic                                                     done_o
);

  import spmm_pkg::*;

  logic [NUM_FEATURE_OUT*WH_DATA_WIDTH-1:0] res_cat;
  logic                                     last_row;

  // Column 0 in the top field
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      res_cat[(NUM_FEATURE_OUT-1-c)*WH_DATA_WIDTH +: WH_DATA_WIDTH] = res_i[c];
    end
  end

  assign wh_data_o = {res_cat, res_num_node_i, res_flag_i};
  assign wh_we_o   = res_vld_i;
  assign last_row  = (wh_addr_o == WH_ADDR_W'(TOTAL_NODES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_addr_o <= '0;
      done_o    <= 1'b0;
    end else if (!spmm_vld_i) begin
      wh_addr_o <= '0;
      done_o    <= 1'b0;
    end else if (res_vld_i) begin
      // Address stays on the last row once the run is complete
      if (last_row) begin
        done_o <= 1'b1;
      end else begin
        wh_addr_o <= wh_addr_o + 1'b1;
      end
    end
  end

endmodule

//--- spmm/spmm_top.sv
/* Sparse-dense product engine */

module spmm_top #(
  parameter int NUM_FEATURE_IN  = spmm_pkg::DEF_NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = spmm_pkg::DEF_NUM_FEATURE_OUT,
  parameter int TOTAL_NODES     = spmm_pkg::DEF_TOTAL_NODES,
  parameter int H_NUM_SPARSE    = spmm_pkg::DEF_H_NUM_SPARSE,
  localparam int COL_W          = $clog2(NUM_FEATURE_IN),
  localparam int ROW_LEN_W      = COL_W + 1,
  localparam int H_ADDR_W       = $clog2(H_NUM_SPARSE),
  localparam int NODE_ADDR_W    = $clog2(TOTAL_NODES),
  localparam int WH_ADDR_W      = $clog2(TOTAL_NODES),
  localparam int H_W            = COL_W + spmm_pkg::DATA_WIDTH,
  localparam int NI_W = ROW_LEN_W + spmm_pkg::NUM_NODE_WIDTH + spmm_pkg::FLAG_WIDTH,
  localparam int WH_W = NUM_FEATURE_OUT * spmm_pkg::WH_DATA_WIDTH
                      + spmm_pkg::NUM_NODE_WIDTH + spmm_pkg::FLAG_WIDTH
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  spmm_vld_i,
  input  logic [H_W-1:0]                                        h_data_i,
  input  logic [NI_W-1:0]                                       node_data_i,
  input  logic [NUM_FEATURE_OUT-1:0][spmm_pkg::DATA_WIDTH-1:0]  wgt_data_i,
  output logic                                                  done_o,
  output logic [H_ADDR_W-1:0]                                   h_addr_o,
  output logic [NODE_ADDR_W-1:0]                                node_addr_o,
  output logic [COL_W-1:0]                                      wgt_addr_o,
  output logic                                                  wh_we_o,
  output logic [WH_ADDR_W-1:0]                                  wh_addr_o,
  output logic [WH_W-1:0]                                       wh_data_o
);

  import spmm_pkg::*;

  // FIFO handshake
  logic            ff_push;
  logic            ff_pop;
  logic            ff_empty;
  logic            ff_full;
  logic [NI_W-1:0] ff_din;
  logic [NI_W-1:0] ff_dout;

  // Element broadcast
  logic                                       elem_vld;
  logic [DATA_WIDTH-1:0]                      elem_val;
  logic                                       elem_last;
  logic [NUM_NODE_WIDTH-1:0]                  elem_num_node;
  logic [FLAG_WIDTH-1:0]                      elem_flag;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] elem_wgt;

  // PE results
  logic [NUM_FEATURE_OUT-1:0]                    pe_vld;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] pe_res;
  logic [NUM_FEATURE_OUT-1:0][NUM_NODE_WIDTH-1:0] pe_num_node;
  logic [NUM_FEATURE_OUT-1:0][FLAG_WIDTH-1:0]    pe_flag;

  spmm_row_fetch #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES),
    .H_NUM_SPARSE    (H_NUM_SPARSE)
  ) u_row_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .spmm_vld_i      (spmm_vld_i),
    .h_data_i        (h_data_i),
    .node_data_i     (node_data_i),
    .wgt_data_i      (wgt_data_i),
    .ff_data_i       (ff_dout),
    .ff_empty_i      (ff_empty),
    .ff_full_i       (ff_full),
    .done_i          (done_o),
    .h_addr_o        (h_addr_o),
    .node_addr_o     (node_addr_o),
    .wgt_addr_o      (wgt_addr_o),
    .ff_push_o       (ff_push),
    .ff_data_o       (ff_din),
    .ff_pop_o        (ff_pop),
    .elem_vld_o      (elem_vld),
    .elem_val_o      (elem_val),
    .elem_last_o     (elem_last),
    .elem_num_node_o (elem_num_node),
    .elem_flag_o     (elem_flag),
    .elem_wgt_o      (elem_wgt)
  );

  node_info_fifo #(
    .DATA_W (NI_W),
    .DEPTH  (NODE_FIFO_DEPTH)
  ) u_node_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (ff_push),
    .pop_i   (ff_pop),
    .din_i   (ff_din),
    .dout_o  (ff_dout),
    .empty_o (ff_empty),
    .full_o  (ff_full)
  );

  // ========================================
  // PE bank, one per output column
  // ========================================

  for (genvar i = 0; i < NUM_FEATURE_OUT; i++) begin : g_pe
    sp_pe #(
      .COL             (i),
      .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
    ) u_pe (
      .clk             (clk),
      .rst_n           (rst_n),
      .elem_vld_i      (elem_vld),
      .elem_val_i      (elem_val),
      .elem_last_i     (elem_last),
      .elem_num_node_i (elem_num_node),
      .elem_flag_i     (elem_flag),
      .elem_wgt_i      (elem_wgt),
      .res_vld_o       (pe_vld[i]),
      .res_o           (pe_res[i]),
      .res_num_node_o  (pe_num_node[i]),
      .res_flag_o      (pe_flag[i])
    );
  end

  // PEs run in lockstep, PE 0 speaks for the bank
  spmm_wh_writer #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES)
  ) u_wh_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .spmm_vld_i     (spmm_vld_i),
    .res_vld_i      (pe_vld[0]),
    .res_i          (pe_res),
    .res_num_node_i (pe_num_node[0]),
    .res_flag_i     (pe_flag[0]),
    .wh_we_o        (wh_we_o),
    .wh_addr_o      (wh_addr_o),
    .wh_data_o      (wh_data_o),
    .done_o         (done_o)
  );

endmodule

//--- dv/tb_clk_gen.sv
/* Testbench clock and reset */

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release just after an edge, like every other driven input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- dv/spmm_asserts.sv
/* SpMM top-level assertions */

module spmm_asserts #(
  parameter int TOTAL_NODES = 8,
  localparam int WH_ADDR_W  = $clog2(TOTAL_NODES)
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 spmm_vld_i,
  input logic                 done_i,
  input logic                 wh_we_i,
  input logic [WH_ADDR_W-1:0] wh_addr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // No WH write once the run is complete
  a_no_write_when_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(wh_we_i && done_i))
    else $error("wh_we_o is high while done_o is high");

  // done_o holds for as long as the request does
  a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i && spmm_vld_i) |=> done_i)
    else $error("done_o fell while spmm_vld_i was still high");

  // Sequential write addresses up to the last row
  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n || !spmm_vld_i)
    (wh_we_i && (wh_addr_i != WH_ADDR_W'(TOTAL_NODES - 1)))
      |=> (wh_addr_i == $past(wh_addr_i) + 1'b1))
    else $error("wh_addr_o did not advance by one after a write");

endmodule

bind spmm_top spmm_asserts #(
  .TOTAL_NODES (TOTAL_NODES)
) u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .spmm_vld_i (spmm_vld_i),
  .done_i     (done_o),
  .wh_we_i    (wh_we_o),
  .wh_addr_i  (wh_addr_o)
);

//--- dv/tb_spmm.sv
/* SpMM engine testbench */

module tb_spmm;

  timeunit 1ns;
  timeprecision 100ps;

  import spmm_pkg::*;

  localparam int COL_W       = $clog2(DEF_NUM_FEATURE_IN);
  localparam int H_W         = COL_W + DATA_WIDTH;
  localparam int NI_W        = COL_W + 1 + NUM_NODE_WIDTH + FLAG_WIDTH;
  localparam int RES_W       = DEF_NUM_FEATURE_OUT * WH_DATA_WIDTH;
  localparam int WH_W        = RES_W + NUM_NODE_WIDTH + FLAG_WIDTH;
  localparam int WGT_W       = DEF_NUM_FEATURE_OUT * DATA_WIDTH;
  localparam int NUM_TESTS   = 2;
  localparam int HOLD_CYCLES = 8;

  // ========================================
  // Stimulus file layout, one block per case
  // ========================================

  localparam int STIM_W    = 80;
  localparam int NI_OFS    = 0;
  localparam int H_OFS     = NI_OFS + DEF_TOTAL_NODES;
  localparam int WGT_OFS   = H_OFS + DEF_H_NUM_SPARSE;
  localparam int EXP_OFS   = WGT_OFS + DEF_NUM_FEATURE_IN;
  localparam int CASE_SIZE = EXP_OFS + DEF_TOTAL_NODES;

  logic                                clk;
  logic                                rst_n;
  logic                                spmm_vld;
  logic [H_W-1:0]                      h_data;
  logic [NI_W-1:0]                     node_data;
  logic [WGT_W-1:0]                    wgt_data;
  logic                                done;
  logic [$clog2(DEF_H_NUM_SPARSE)-1:0] h_addr;
  logic [$clog2(DEF_TOTAL_NODES)-1:0]  node_addr;
  logic [COL_W-1:0]                    wgt_addr;
  logic                                wh_we;
  logic [$clog2(DEF_TOTAL_NODES)-1:0]  wh_addr;
  logic [WH_W-1:0]                     wh_data;

  logic [STIM_W-1:0] stim [NUM_TESTS*CASE_SIZE];
  logic [WH_W-1:0]   wh_mem [DEF_TOTAL_NODES];
  int                wr_count [DEF_TOTAL_NODES];
  int                last_wr_addr;
  int                cur_case;
  int                h_addr_q;
  int                node_addr_q;
  int                wgt_addr_q;
  int                value_errors;
  int                other_errors;
  integer            seed;

  tb_clk_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (3)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  spmm_top #(
    .NUM_FEATURE_IN  (DEF_NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (DEF_NUM_FEATURE_OUT),
    .TOTAL_NODES     (DEF_TOTAL_NODES),
    .H_NUM_SPARSE    (DEF_H_NUM_SPARSE)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .spmm_vld_i  (spmm_vld),
    .h_data_i    (h_data),
    .node_data_i (node_data),
    .wgt_data_i  (wgt_data),
    .done_o      (done),
    .h_addr_o    (h_addr),
    .node_addr_o (node_addr),
    .wgt_addr_o  (wgt_addr),
    .wh_we_o     (wh_we),
    .wh_addr_o   (wh_addr),
    .wh_data_o   (wh_data)
  );

  // File keeps fields nibble aligned, LLNNF
  function automatic logic [NI_W-1:0] pack_node_info(input logic [STIM_W-1:0] w);
    return {w[12+COL_W:12], w[11:4], w[0]};
  endfunction

  // Columns, node count and flag from the expected entry
  function automatic logic [WH_W-1:0] pack_expected(input logic [STIM_W-1:0] w);
    return {w[12+RES_W-1:12], w[11:4], w[0]};
  endfunction

  function automatic int case_nnz(input int t);
    int n;
    n = 0;
    for (int r = 0; r < DEF_TOTAL_NODES; r++) begin
      n += int'(stim[t*CASE_SIZE + NI_OFS + r][12+COL_W:12]);
    end
    return n;
  endfunction

  // ========================================
  // Memory models and write recorder
  // ========================================

  always @(negedge clk) begin
    h_addr_q    = int'(h_addr);
    node_addr_q = int'(node_addr);
    wgt_addr_q  = int'(wgt_addr);
  end

  // One cycle of read latency
  always @(posedge clk) begin
    #1;
    h_data    = stim[cur_case*CASE_SIZE + H_OFS + h_addr_q][H_W-1:0];
    node_data = pack_node_info(stim[cur_case*CASE_SIZE + NI_OFS + node_addr_q]);
    wgt_data  = stim[cur_case*CASE_SIZE + WGT_OFS + wgt_addr_q][WGT_W-1:0];
  end

  always @(negedge clk) begin
    if (rst_n && wh_we) begin
      if (done) begin
        $display("Case %0d: row %0d written after done_o rose", cur_case, wh_addr);
        other_errors++;
      end
      if (int'(wh_addr) != last_wr_addr + 1) begin
        $display("Case %0d: row %0d written out of order after row %0d",
                 cur_case, wh_addr, last_wr_addr);
        other_errors++;
      end
      wh_mem[wh_addr]   = wh_data;
      wr_count[wh_addr] = wr_count[wh_addr] + 1;
      last_wr_addr      = int'(wh_addr);
    end
  end

  task automatic check_results(input int t);
    logic [WH_W-1:0] exp_word;
    logic [WH_W-1:0] act_word;
    for (int r = 0; r < DEF_TOTAL_NODES; r++) begin
      if (wr_count[r] != 1) begin
        $display("Case %0d: row %0d was written %0d times instead of once",
                 t, r, wr_count[r]);
        other_errors++;
      end else begin
        exp_word = pack_expected(stim[t*CASE_SIZE + EXP_OFS + r]);
        act_word = wh_mem[r];
        for (int c = 0; c < DEF_NUM_FEATURE_OUT; c++) begin
          if (act_word[WH_W-1-c*WH_DATA_WIDTH -: WH_DATA_WIDTH]
              !== exp_word[WH_W-1-c*WH_DATA_WIDTH -: WH_DATA_WIDTH]) begin
            $display("[ERROR] case%0d_row%0d_col%0d: expected %h, actual %h", t, r, c,
                     exp_word[WH_W-1-c*WH_DATA_WIDTH -: WH_DATA_WIDTH],
                     act_word[WH_W-1-c*WH_DATA_WIDTH -: WH_DATA_WIDTH]);
            value_errors++;
          end
        end
        if (act_word[8:1] !== exp_word[8:1]) begin
          $display("[ERROR] case%0d_row%0d_node_count: expected %h, actual %h", t, r,
                   exp_word[8:1], act_word[8:1]);
          value_errors++;
        end
        if (act_word[0] !== exp_word[0]) begin
          $display("[ERROR] case%0d_row%0d_flag: expected %b, actual %b", t, r,
                   exp_word[0], act_word[0]);
          value_errors++;
        end
      end
    end
  endtask

  task automatic run_case(input int t);
    int limit;
    int cycles;
    cur_case     = t;
    last_wr_addr = -1;
    for (int r = 0; r < DEF_TOTAL_NODES; r++) begin
      wr_count[r] = 0;
    end
    limit = 2 * case_nnz(t) + 20;
    @(posedge clk);
    #1 spmm_vld = 1'b1;
    cycles = 0;
    while (done !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Case %0d: done_o did not rise within %0d cycles", t, limit);
      other_errors++;
    end
    // Request held, done must stay and writes must stop
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      if (done !== 1'b1) begin
        $display("Case %0d: done_o fell while spmm_vld_i was held", t);
        other_errors++;
      end
    end
    check_results(t);
    @(posedge clk);
    #1 spmm_vld = 1'b0;
    repeat (2) @(negedge clk);
    if (done !== 1'b0 || wh_addr !== '0 || h_addr !== '0 || node_addr !== '0) begin
      $display("[ERROR] case%0d_release: expected done=0 wh_addr=0 h_addr=0 node_addr=0,",
               t);
      $display("        actual %b %0d %0d %0d", done, wh_addr, h_addr, node_addr);
      value_errors++;
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin
    int gap;
    spmm_vld     = 1'b0;
    h_data       = '0;
    node_data    = '0;
    wgt_data     = '0;
    h_addr_q     = 0;
    node_addr_q  = 0;
    wgt_addr_q   = 0;
    cur_case     = 0;
    last_wr_addr = -1;
    value_errors = 0;
    other_errors = 0;
    seed         = 32'h0b511752;
    for (int i = 0; i < NUM_TESTS*CASE_SIZE; i++) begin
      stim[i] = '0;
    end
    for (int r = 0; r < DEF_TOTAL_NODES; r++) begin
      wr_count[r] = 0;
    end
    $readmemh("dv/spmm_stim.txt", stim);
    @(posedge rst_n);
    repeat (5) begin
      @(negedge clk);
      if (wh_we !== 1'b0 || done !== 1'b0) begin
        $display("[ERROR] idle_after_reset: expected wh_we=0 done=0, actual wh_we=%b done=%b",
                 wh_we, done);
        value_errors++;
      end
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (t > 0) begin
        gap = $unsigned($random(seed)) % 16;
        repeat (gap) @(posedge clk);
      end
      run_case(t);
    end
    $display("Result: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the nonzero count of every case
  initial begin
    int limit;
    @(posedge rst_n);
    limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += 4 * case_nnz(t) + 40;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the runs did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- dv/spmm_stim.txt
// Per case: node info LLNNF (row length, node count, flag), H data CVV (column, value),
// weight rows w3w2w1w0, expected WH col0 col1 col2 col3 (4 hex each) then NN F
// Case 0, 17 nonzeros
@00 03031 01050 01020 02101 03071 04010 010C1 02FF0
@08 005 2FE 403 107 000 380 580 001 580 F80 103 204 4FF 902 9FF 302 4FB
@28 04030201 020500FF 0100FD0A 80FE0700 02020202 03000180 00000000 00000000
00000000 F808FC04 00000000 00000000 00000000 00000000 00000000 01000080
@38 FFF7001600150018031 FFF900000023000E050 0000000000000000020 4000FC0001003E80101
8001FF820003FE04071 002BFFEA001DFFF8010 FFFC0004FFF800080C1 FFF60004FFF2FEF6FF0
// Case 1, 25 nonzeros
@40 08200 01011 04041 02110 01091 01000 03331 05800
@48 80A 914 A1E B28 CFB DFA EF9 FF8 77F 0FD 104 2FB 306
409 502 680 000 3FF 601 7FF 180 480 532 701 F02
@68 00000001 00000100 00010000 01000000 FFFFFFFF FA06FD03 9CCE3264 7F7F7F7F
01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
@78 004A004A004A004A200 3F013F013F013F01011 FFFD0004FFFB0006041 FFFDFFF10003FFEB110
CE00E70019003200091 0000000000000000000 FFE5FFB3FF4FFF1C331 0197FFEB022DFFD5800

//--- filelist.f
common/spmm_pkg.sv
src/node_info_fifo.sv
spmm/spmm_row_fetch.sv
spmm/sp_pe.sv
spmm/spmm_wh_writer.sv
spmm/spmm_top.sv
dv/tb_clk_gen.sv
dv/spmm_asserts.sv
dv/tb_spmm.sv

//--- Bender.yml
package:
  name: spmm

sources:
  - files:
      - common/spmm_pkg.sv
      - src/node_info_fifo.sv
      - spmm/spmm_row_fetch.sv
      - spmm/sp_pe.sv
      - spmm/spmm_wh_writer.sv
      - spmm/spmm_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/spmm_asserts.sv
      - dv/tb_spmm.sv
